// File: build.f
ppu_pkg.sv
ppu_cfg_decode.sv
ppu_scanline_stage.sv
ppu_range_stage.sv
ppu_out_top.sv
tb_ppu_out.sv

// File: ppu_cfg_decode.sv
/*
  Configuration loader for the video output path
  Captures a word over a four-phase req/ack handshake and decodes
  the output mode, sync polarity, range and scanline settings
*/

`timescale 1ns/1ps

module ppu_cfg_decode (
  input  logic                           VCLK_Tx,
  input  logic                           nVRST_Tx,
  input  logic                           cfg_req_i,
  input  logic [ppu_pkg::cfg_w-1:0]      cfg_word_i,
  input  logic                           pal_i,
  output logic                           cfg_ack_o,
  output logic [ppu_pkg::vid_mode_w-1:0] vid_mode_o,
  output logic                           hsync_neg_o,
  output logic                           vsync_neg_o,
  output logic                           limited_rgb_o,
  output logic                           sl_en_o,
  output logic [ppu_pkg::sl_str_w-1:0]   sl_str_o
);

  logic [ppu_pkg::cfg_w-1:0]      cfg_q;     // Captured word
  logic                           cap_q;     // Capture done, ack follows
  logic                           out_60;    // 60 Hz output selected
  logic [2:0]                     tgt_res;
  logic [ppu_pkg::vid_mode_w-1:0] mode_nxt;

  // ========================================
  // Four-phase handshake
  // ========================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      cfg_q     <= '0;
      cap_q     <= 1'b0;
      cfg_ack_o <= 1'b0;
    end else begin
      cap_q <= 1'b0;
      if (cfg_req_i && !cfg_ack_o && !cap_q) begin  // New request, take the word
        cfg_q <= cfg_word_i;
        cap_q <= 1'b1;
      end
      if (cap_q)
        cfg_ack_o <= 1'b1;      // Ack one cycle after capture
      else if (!cfg_req_i)
        cfg_ack_o <= 1'b0;      // Release once req is gone
    end
  end

  // ========================================
  // Mode decode
  // ========================================

  assign tgt_res = cfg_q[ppu_pkg::tgt_res_msb:ppu_pkg::tgt_res_lsb];

  always_comb begin
    // Forcing a rate is not allowed in low-latency mode
    if (cfg_q[ppu_pkg::force60_bit] && !cfg_q[ppu_pkg::llm_bit])
      out_60 = 1'b1;
    else if (cfg_q[ppu_pkg::force50_bit] && !cfg_q[ppu_pkg::llm_bit])
      out_60 = 1'b0;
    else
      out_60 = !pal_i;

    case (tgt_res)
      ppu_pkg::tgt_720p:  mode_nxt = out_60 ? ppu_pkg::mode_720p60  : ppu_pkg::mode_720p50;
      ppu_pkg::tgt_960p:  mode_nxt = out_60 ? ppu_pkg::mode_960p60  : ppu_pkg::mode_960p50;
      ppu_pkg::tgt_1080p: mode_nxt = out_60 ? ppu_pkg::mode_1080p60 : ppu_pkg::mode_1080p50;
      ppu_pkg::tgt_1200p: mode_nxt = out_60 ? ppu_pkg::mode_1200p60 : ppu_pkg::mode_1200p50;
      default: begin
        // 480p class, VGA only exists at 60 Hz
        if (!out_60)
          mode_nxt = ppu_pkg::mode_576p50;
        else if (cfg_q[ppu_pkg::vga480p_bit])
          mode_nxt = ppu_pkg::mode_vga60;
        else
          mode_nxt = ppu_pkg::mode_480p60;
      end
    endcase
  end

  // Decoded settings, refreshed every cycle so pal_i is followed
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vid_mode_o    <= ppu_pkg::mode_480p60;
      hsync_neg_o   <= 1'b1;    // 480p uses active-low syncs
      vsync_neg_o   <= 1'b1;
      limited_rgb_o <= 1'b0;
      sl_en_o       <= 1'b0;
      sl_str_o      <= '0;
    end else begin
      vid_mode_o    <= mode_nxt;
      hsync_neg_o   <= (mode_nxt[2:0] <= ppu_pkg::neg_sync_max_idx);
      vsync_neg_o   <= (mode_nxt[2:0] <= ppu_pkg::neg_sync_max_idx);
      limited_rgb_o <= cfg_q[ppu_pkg::limrgb_bit];
      sl_en_o       <= cfg_q[ppu_pkg::sl_en_bit];
      // 16*(field+1)-1, i.e. the field with a low nibble of ones
      sl_str_o      <= {cfg_q[ppu_pkg::sl_str_msb:ppu_pkg::sl_str_lsb], 4'hF};
    end
  end

  // ========================================
  // Handshake checks
  // ========================================

  // Ack only answers a request seen on the previous edge
  ack_needs_req: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    $rose(cfg_ack_o) |-> $past(cfg_req_i));

  // Host holds the word until the decoder acknowledges
  word_stable: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    (cfg_req_i && !cfg_ack_o && $past(cfg_req_i && !cfg_ack_o)) |-> $stable(cfg_word_i));

endmodule

// File: ppu_out_top.sv
/*
  Top level of the HDMI video output path
  Config decoder, scanline stage and range stage, five cycles in total
*/

`timescale 1ns/1ps

module ppu_out_top #(
  parameter int color_w = ppu_pkg::color_w
) (
  input  logic                           VCLK_Tx,
  input  logic                           nVRST_Tx,
  input  logic                           cfg_req_i,
  input  logic [ppu_pkg::cfg_w-1:0]      cfg_word_i,
  input  logic                           pal_i,
  input  logic                           hsync_i,
  input  logic                           vsync_i,
  input  logic                           de_i,
  input  logic                           draw_sl_i,
  input  logic [3*color_w-1:0]           rgb_i,
  output logic                           cfg_ack_o,
  output logic [ppu_pkg::vid_mode_w-1:0] vid_mode_o,
  output logic                           HSYNC_o,
  output logic                           VSYNC_o,
  output logic                           DE_o,
  output logic [3*color_w-1:0]           VD_o
);

  // Decoded configuration
  logic                         hsync_neg, vsync_neg;
  logic                         limited_rgb;
  logic                         sl_en;
  logic [ppu_pkg::sl_str_w-1:0] sl_str;

  // Between the two stages
  logic                 sl_hsync, sl_vsync, sl_de;
  logic [3*color_w-1:0] sl_rgb;

  ppu_cfg_decode cfg_decode_u (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .cfg_req_i     (cfg_req_i),
    .cfg_word_i    (cfg_word_i),
    .pal_i         (pal_i),
    .cfg_ack_o     (cfg_ack_o),
    .vid_mode_o    (vid_mode_o),
    .hsync_neg_o   (hsync_neg),
    .vsync_neg_o   (vsync_neg),
    .limited_rgb_o (limited_rgb),
    .sl_en_o       (sl_en),
    .sl_str_o      (sl_str)
  );

  // ========================================
  // Pixel pipeline
  // ========================================

  ppu_scanline_stage #(
    .color_w (color_w)
  ) scanline_u (
    .VCLK_Tx   (VCLK_Tx),
    .nVRST_Tx  (nVRST_Tx),
    .hsync_i   (hsync_i),
    .vsync_i   (vsync_i),
    .de_i      (de_i),
    .draw_sl_i (draw_sl_i),
    .rgb_i     (rgb_i),
    .sl_en_i   (sl_en),
    .sl_str_i  (sl_str),
    .hsync_o   (sl_hsync),
    .vsync_o   (sl_vsync),
    .de_o      (sl_de),
    .rgb_o     (sl_rgb)
  );

  ppu_range_stage #(
    .color_w (color_w)
  ) range_u (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .hsync_i       (sl_hsync),
    .vsync_i       (sl_vsync),
    .de_i          (sl_de),
    .rgb_i         (sl_rgb),
    .limited_rgb_i (limited_rgb),
    .hsync_neg_i   (hsync_neg),
    .vsync_neg_i   (vsync_neg),
    .HSYNC_o       (HSYNC_o),
    .VSYNC_o       (VSYNC_o),
    .DE_o          (DE_o),
    .VD_o          (VD_o)
  );

endmodule

// File: ppu_pkg.sv
/*
  Shared constants of the HDMI video output path
  Configuration word layout, output mode codes and RGB range constants
  Referenced by scoped name from the RTL and the testbench
*/

package ppu_pkg;

  // ========================================
  // Data widths
  // ========================================

  localparam int color_w = 8;    // Bits per colour channel
  localparam int cfg_w   = 16;   // Configuration word from the host
  localparam int sl_str_w = 8;   // Expanded scanline strength

  // ========================================
  // Configuration word fields
  // ========================================

  localparam int tgt_res_lsb  = 0;   // Target resolution, 3 bits
  localparam int tgt_res_msb  = 2;
  localparam int vga480p_bit  = 3;   // Use VGA instead of 480p
  localparam int force60_bit  = 4;
  localparam int force50_bit  = 5;
  localparam int llm_bit      = 6;   // Low-latency mode blocks forcing
  localparam int limrgb_bit   = 7;   // Limited RGB range
  localparam int sl_en_bit    = 8;   // Scanline enable
  localparam int sl_str_lsb   = 9;   // Scanline strength field, 4 bits
  localparam int sl_str_msb   = 12;
  // Bits 15 to 13 are spare

  // Target resolution codes, 0 and 5..7 fall back to the 480p class
  localparam logic [2:0] tgt_720p  = 3'd1;
  localparam logic [2:0] tgt_960p  = 3'd2;
  localparam logic [2:0] tgt_1080p = 3'd3;
  localparam logic [2:0] tgt_1200p = 3'd4;

  // ========================================
  // Output video mode codes
  // ========================================

  // Bit 3 flags 50 Hz, bits 2..0 hold the resolution index
  localparam int vid_mode_w = 4;

  localparam logic [vid_mode_w-1:0] mode_480p60  = 4'h0;
  localparam logic [vid_mode_w-1:0] mode_vga60   = 4'h1;
  localparam logic [vid_mode_w-1:0] mode_720p60  = 4'h2;
  localparam logic [vid_mode_w-1:0] mode_960p60  = 4'h3;
  localparam logic [vid_mode_w-1:0] mode_1080p60 = 4'h4;
  localparam logic [vid_mode_w-1:0] mode_1200p60 = 4'h5;

  localparam logic [vid_mode_w-1:0] mode_576p50  = 4'h8;
  localparam logic [vid_mode_w-1:0] mode_720p50  = 4'hA;
  localparam logic [vid_mode_w-1:0] mode_960p50  = 4'hB;
  localparam logic [vid_mode_w-1:0] mode_1080p50 = 4'hC;
  localparam logic [vid_mode_w-1:0] mode_1200p50 = 4'hD;

  // Highest resolution index that still uses active-low syncs
  localparam logic [2:0] neg_sync_max_idx = 3'd1;

  // ========================================
  // Limited RGB range
  // ========================================

  // Full range 0..255 maps onto 16..235
  localparam logic [7:0] limit_coeff  = 8'd220;
  localparam logic [7:0] limit_offset = 8'd16;

endpackage

// File: ppu_range_stage.sv
/*
  RGB range stage and final output registers
  Optionally compresses full range RGB to 16..235 and applies the
  sync polarity of the output mode, three cycles deep
*/

`timescale 1ns/1ps

module ppu_range_stage #(
  parameter int color_w = 8
) (
  input  logic                 VCLK_Tx,
  input  logic                 nVRST_Tx,
  input  logic                 hsync_i,
  input  logic                 vsync_i,
  input  logic                 de_i,
  input  logic [3*color_w-1:0] rgb_i,
  input  logic                 limited_rgb_i,
  input  logic                 hsync_neg_i,
  input  logic                 vsync_neg_i,
  output logic                 HSYNC_o,
  output logic                 VSYNC_o,
  output logic                 DE_o,
  output logic [3*color_w-1:0] VD_o
);

  localparam int prod_w = color_w + 8;   // Channel times byte-wide coefficient

  logic [prod_w-1:0]    prod_w_c [3];    // Combinational c*220
  logic [color_w:0]     slice_q  [3];    // P = floor(c*220/128)
  logic [color_w-1:0]   round_q  [3];    // floor(P/2) + lsb
  logic [3*color_w-1:0] full_q1, full_q2;
  logic                 hsync_q1, hsync_q2, vsync_q1, vsync_q2, de_q1, de_q2;

  always_comb begin
    for (int ch = 0; ch < 3; ch++)
      prod_w_c[ch] = rgb_i[ch*color_w +: color_w] * ppu_pkg::limit_coeff;
  end

  // ========================================
  // Steps 1 and 2: slice and round
  // ========================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      full_q1  <= '0;
      full_q2  <= '0;
      hsync_q1 <= 1'b0;
      hsync_q2 <= 1'b0;
      vsync_q1 <= 1'b0;
      vsync_q2 <= 1'b0;
      de_q1    <= 1'b0;
      de_q2    <= 1'b0;
      for (int ch = 0; ch < 3; ch++) begin
        slice_q[ch] <= '0;
        round_q[ch] <= '0;
      end
    end else begin
      full_q1  <= rgb_i;     // Full range path runs alongside
      full_q2  <= full_q1;
      hsync_q1 <= hsync_i;
      hsync_q2 <= hsync_q1;
      vsync_q1 <= vsync_i;
      vsync_q2 <= vsync_q1;
      de_q1    <= de_i;
      de_q2    <= de_q1;
      for (int ch = 0; ch < 3; ch++) begin
        slice_q[ch] <= prod_w_c[ch][prod_w-1:7];                  // Drop 7 lsbs
        round_q[ch] <= slice_q[ch][color_w:1] + slice_q[ch][0];   // Round half up
      end
    end
  end

  // ========================================
  // Step 3: offset, polarity, outputs
  // ========================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      HSYNC_o <= 1'b0;
      VSYNC_o <= 1'b0;
      DE_o    <= 1'b0;
      VD_o    <= '0;
    end else begin
      HSYNC_o <= hsync_q2 ^ hsync_neg_i;   // Invert for active-low modes
      VSYNC_o <= vsync_q2 ^ vsync_neg_i;
      DE_o    <= de_q2;
      for (int ch = 0; ch < 3; ch++) begin
        if (limited_rgb_i)
          VD_o[ch*color_w +: color_w] <= round_q[ch] + color_w'(ppu_pkg::limit_offset);
        else
          VD_o[ch*color_w +: color_w] <= full_q2[ch*color_w +: color_w];
      end
    end
  end

  // Limited output stays inside the video range
  for (genvar gch = 0; gch < 3; gch++) begin : g_chk
    in_range: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
      $past(limited_rgb_i) |->
        (VD_o[gch*color_w +: color_w] >= ppu_pkg::limit_offset &&
         VD_o[gch*color_w +: color_w] <= ppu_pkg::limit_offset + ppu_pkg::limit_coeff - 1));
  end

endmodule

// File: ppu_scanline_stage.sv
/*
  Scanline emulation stage
  Darkens marked pixels by the configured strength, two cycles deep
*/

`timescale 1ns/1ps

module ppu_scanline_stage #(
  parameter int color_w = 8
) (
  input  logic                         VCLK_Tx,
  input  logic                         nVRST_Tx,
  input  logic                         hsync_i,
  input  logic                         vsync_i,
  input  logic                         de_i,
  input  logic                         draw_sl_i,
  input  logic [3*color_w-1:0]         rgb_i,
  input  logic                         sl_en_i,
  input  logic [ppu_pkg::sl_str_w-1:0] sl_str_i,
  output logic                         hsync_o,
  output logic                         vsync_o,
  output logic                         de_o,
  output logic [3*color_w-1:0]         rgb_o
);

  localparam int prod_w = color_w + ppu_pkg::sl_str_w;

  logic [3*color_w-1:0] rgb_q;        // Input pixel, first step
  logic [prod_w-1:0]    prod_q [3];   // Channel times strength
  logic                 dark_q;       // Pixel lies on a scanline
  logic                 hsync_q, vsync_q, de_q;

  // ========================================
  // Step 1: product and darken decision
  // ========================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      rgb_q   <= '0;
      dark_q  <= 1'b0;
      hsync_q <= 1'b0;
      vsync_q <= 1'b0;
      de_q    <= 1'b0;
      for (int ch = 0; ch < 3; ch++)
        prod_q[ch] <= '0;
    end else begin
      rgb_q   <= rgb_i;
      dark_q  <= sl_en_i & draw_sl_i;
      hsync_q <= hsync_i;
      vsync_q <= vsync_i;
      de_q    <= de_i;
      for (int ch = 0; ch < 3; ch++)
        prod_q[ch] <= rgb_i[ch*color_w +: color_w] * sl_str_i;   // c*S
    end
  end

  // ========================================
  // Step 2: subtract scaled product
  // ========================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      rgb_o   <= '0;
      hsync_o <= 1'b0;
      vsync_o <= 1'b0;
      de_o    <= 1'b0;
    end else begin
      hsync_o <= hsync_q;
      vsync_o <= vsync_q;
      de_o    <= de_q;
      for (int ch = 0; ch < 3; ch++) begin
        if (dark_q)   // c - floor(c*S/256)
          rgb_o[ch*color_w +: color_w] <= rgb_q[ch*color_w +: color_w]
                                          - prod_q[ch][prod_w-1:ppu_pkg::sl_str_w];
        else
          rgb_o[ch*color_w +: color_w] <= rgb_q[ch*color_w +: color_w];
      end
    end
  end

  // Darkening never brightens, no wrap in the subtraction
  for (genvar gch = 0; gch < 3; gch++) begin : g_chk
    no_brighten: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
      rgb_o[gch*color_w +: color_w] <= $past(rgb_q[gch*color_w +: color_w]));
  end

endmodule

// File: ppu_stim.txt
// kind (test number, record type) then four hex fields per line
// type 1 config: word, pal_i, expected vid_mode_o, unused
// type 2 pixel: {hsync,vsync,de,draw_sl}, rgb, expected {HSYNC,VSYNC,DE}, expected VD
// type 3 random pixels: count, unused, unused, unused
21 0000 0 0 0
21 0000 1 8 0
21 0008 0 1 0
21 0001 1 A 0
21 0012 1 3 0
21 0052 1 B 0
21 0023 0 C 0
21 0063 0 4 0
21 0004 0 5 0
21 0005 0 0 0
31 0000 0 0 0
32 2 123456 7 123456
32 A FF00AA 3 FF00AA
32 4 000000 4 000000
31 0003 0 4 0
32 A 0A0B0C 5 0A0B0C
32 6 FFFFFF 3 FFFFFF
33 6 0 0 0
41 0101 0 2 0
42 3 FF8010 1 F17910
42 2 FF8010 1 FF8010
41 0F01 0 2 0
42 B 646464 5 333333
41 1F01 0 2 0
42 3 FF8001 1 010101
43 6 0 0 0
51 0080 0 0 0
52 2 0080FF 7 107EEB
52 2 FF0080 7 EB107E
53 8 0 0 0
51 0781 0 2 0
53 8 0 0 0
61 0004 0 5 0
62 A 102030 5 102030
61 0088 0 1 0
62 A 102030 3 1E2C39
63 4 0 0 0

// File: tb_ppu_out.sv
/*
  Self-checking testbench for the HDMI video output path
  Replays the config and pixel vectors of ppu_stim.txt and checks each
  pixel at the outputs five cycles after it was driven
*/

`timescale 1ns/1ps

module tb_ppu_out;

  localparam int cw        = ppu_pkg::color_w;
  localparam int rec_w     = 5;    // Hex words per stimulus record
  localparam int max_rec   = 64;
  localparam int ack_limit = 20;   // Cycles allowed per handshake phase
  localparam int lat       = 5;    // Input to output latency

  logic                           VCLK_Tx, nVRST_Tx;
  logic                           cfg_req_i, pal_i;
  logic [ppu_pkg::cfg_w-1:0]      cfg_word_i;
  logic                           hsync_i, vsync_i, de_i, draw_sl_i;
  logic [3*cw-1:0]                rgb_i;
  logic                           cfg_ack_o;
  logic [ppu_pkg::vid_mode_w-1:0] vid_mode_o;
  logic                           HSYNC_o, VSYNC_o, DE_o;
  logic [3*cw-1:0]                VD_o;

  logic [31:0]               stim_mem [rec_w*max_rec];
  logic [ppu_pkg::cfg_w-1:0] cur_word;   // Model of the loaded config
  logic                      cur_pal;
  integer                    seed;
  int cyc = 0;
  int checks = 0, errors = 0;
  int t_checks = 0, t_errors = 0;        // Counts when the test began

  // Expected outputs with one entry per driven pixel
  int              exp_due [$];
  logic [2:0]      exp_ctl [$];
  logic [3*cw-1:0] exp_vd  [$];

  ppu_out_top DUT (
    .VCLK_Tx (VCLK_Tx), .nVRST_Tx (nVRST_Tx),
    .cfg_req_i (cfg_req_i), .cfg_word_i (cfg_word_i), .pal_i (pal_i),
    .hsync_i (hsync_i), .vsync_i (vsync_i), .de_i (de_i),
    .draw_sl_i (draw_sl_i), .rgb_i (rgb_i),
    .cfg_ack_o (cfg_ack_o), .vid_mode_o (vid_mode_o),
    .HSYNC_o (HSYNC_o), .VSYNC_o (VSYNC_o), .DE_o (DE_o), .VD_o (VD_o)
  );

  initial begin
    VCLK_Tx = 1'b0;
    forever #10 VCLK_Tx = ~VCLK_Tx;   // 50 MHz
  end

  always @(posedge VCLK_Tx) cyc <= cyc + 1;

  // ========================================
  // Reference model
  // ========================================

  function automatic logic [3:0] model_mode(input logic [15:0] w, input logic pal);
    logic out60;
    int   tgt, idx;
    out60 = !pal;
    if (w[ppu_pkg::force60_bit] && !w[ppu_pkg::llm_bit])
      out60 = 1'b1;
    else if (w[ppu_pkg::force50_bit] && !w[ppu_pkg::llm_bit])
      out60 = 1'b0;
    tgt = w[2:0];
    if (tgt >= 1 && tgt <= 4)
      idx = tgt + 1;
    else if (out60 && w[ppu_pkg::vga480p_bit])
      idx = 1;                          // VGA instead of 480p
    else
      idx = 0;
    return {!out60, idx[2:0]};
  endfunction

  // Returns {HSYNC, VSYNC, DE, VD} for one input pixel
  function automatic logic [3*cw+2:0] model_pixel(input logic [3:0] ctl,
                                                  input logic [3*cw-1:0] rgb);
    logic [3:0]      mode;
    logic            neg;
    int              s, c, p;
    logic [3*cw-1:0] vd;
    mode = model_mode(cur_word, cur_pal);
    neg  = (mode[2:0] <= 3'd1);         // 480p and VGA sync low
    s    = 16 * (cur_word[ppu_pkg::sl_str_msb:ppu_pkg::sl_str_lsb] + 1) - 1;
    for (int ch = 0; ch < 3; ch++) begin
      c = rgb[ch*cw +: cw];
      if (cur_word[ppu_pkg::sl_en_bit] && ctl[0])
        c = c - (c * s) / 256;
      if (cur_word[ppu_pkg::limrgb_bit]) begin
        p = (c * 220) / 128;
        c = p / 2 + p % 2 + 16;
      end
      vd[ch*cw +: cw] = c[cw-1:0];
    end
    return {ctl[3] ^ neg, ctl[2] ^ neg, ctl[1], vd};
  endfunction

  // ========================================
  // Checking and reporting
  // ========================================

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch %s: got 0x%0h expected 0x%0h at cycle %0d", name, got, exp, cyc);
    end
  endtask

  task automatic finish_run();
    $display("tests done: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  endtask

  task automatic abort_run(input string why);
    errors++;
    $display("timeout: %s", why);
    finish_run();
  endtask

  function automatic string test_name(input int id);
    case (id)
      1:       return "reset state";
      2:       return "handshake";
      3:       return "pass-through";
      4:       return "scanlines";
      5:       return "limited rgb";
      default: return "reconfiguration";
    endcase
  endfunction

  task automatic end_test(input int id);
    $display("test %0d %s: %0d checks, %0d errors", id, test_name(id),
             checks - t_checks, errors - t_errors);
    t_checks = checks;
    t_errors = errors;
  endtask

  // Compare the oldest pending pixel once its output is due
  always @(negedge VCLK_Tx) begin
    if (exp_due.size() > 0 && exp_due[0] == cyc) begin
      check_val("HSYNC_o", HSYNC_o, exp_ctl[0][2]);
      check_val("VSYNC_o", VSYNC_o, exp_ctl[0][1]);
      check_val("DE_o", DE_o, exp_ctl[0][0]);
      check_val("VD_o", VD_o, exp_vd[0]);
      exp_due.delete(0);
      exp_ctl.delete(0);
      exp_vd.delete(0);
    end
  end

  // ========================================
  // Drivers
  // ========================================

  task automatic drive_pixel(input logic [3:0] ctl, input logic [3*cw-1:0] rgb,
                             input logic [2:0] e_ctl, input logic [3*cw-1:0] e_vd);
    @(posedge VCLK_Tx);
    #1;
    {hsync_i, vsync_i, de_i, draw_sl_i} = ctl;
    rgb_i = rgb;
    exp_due.push_back(cyc + lat);
    exp_ctl.push_back(e_ctl);
    exp_vd.push_back(e_vd);
  endtask

  task automatic drive_idle();
    @(posedge VCLK_Tx);
    #1;
    {hsync_i, vsync_i, de_i, draw_sl_i} = 4'b0;
    rgb_i = '0;
  endtask

  // Let every pixel in flight reach the outputs
  task automatic drain_pipe();
    int n;
    n = 0;
    while (exp_due.size() > 0 && n < 2 * lat) begin
      drive_idle();
      n++;
    end
    if (exp_due.size() > 0)
      abort_run("pixel pipeline did not drain");
  endtask

  task automatic load_config(input logic [15:0] word, input logic pal, input logic [3:0] e_mode);
    int n;
    drain_pipe();
    @(posedge VCLK_Tx);
    #1;
    cfg_word_i = word;
    pal_i      = pal;
    cfg_req_i  = 1'b1;
    n = 0;
    while (cfg_ack_o !== 1'b1 && n < ack_limit) begin
      @(posedge VCLK_Tx);
      #1;
      n++;
    end
    if (cfg_ack_o !== 1'b1) begin
      abort_run("cfg_ack_o never rose after cfg_req_i");
    end else begin
      check_val("cfg_ack_o rise delay", n, 2);
      check_val("vid_mode_o", vid_mode_o, e_mode);
      cfg_req_i = 1'b0;
      n = 0;
      while (cfg_ack_o !== 1'b0 && n < ack_limit) begin
        @(posedge VCLK_Tx);
        #1;
        n++;
      end
      if (cfg_ack_o !== 1'b0) begin
        abort_run("cfg_ack_o stayed high after cfg_req_i fell");
      end else begin
        check_val("cfg_ack_o fall delay", n, 1);
        cur_word = word;
        cur_pal  = pal;
      end
    end
  endtask

  // ========================================
  // Main sequence
  // ========================================

  initial begin : main_seq
    int                idx, test_id;
    logic [3:0]        ctl;
    logic [3*cw-1:0]   rgb;
    logic [3*cw+2:0]   e;
    logic [31:0]       r;
    seed       = 14;
    nVRST_Tx   = 1'b0;
    cfg_req_i  = 1'b0;
    cfg_word_i = '0;
    pal_i      = 1'b0;
    {hsync_i, vsync_i, de_i, draw_sl_i} = 4'b0;
    rgb_i      = '0;
    cur_word   = '0;
    cur_pal    = 1'b0;
    for (int i = 0; i < rec_w * max_rec; i++)
      stim_mem[i] = '0;                 // Unused records read as end
    $readmemh("ppu_stim.txt", stim_mem);

    repeat (8) @(posedge VCLK_Tx);
    #1 nVRST_Tx = 1'b1;
    @(negedge VCLK_Tx);
    check_val("cfg_ack_o", cfg_ack_o, 0);
    check_val("DE_o", DE_o, 0);
    check_val("HSYNC_o", HSYNC_o, 0);
    check_val("VSYNC_o", VSYNC_o, 0);
    check_val("VD_o", VD_o, 0);
    check_val("vid_mode_o", vid_mode_o, ppu_pkg::mode_480p60);
    end_test(1);

    if (stim_mem[0] === 32'h0) begin
      errors++;
      $display("stimulus file ppu_stim.txt is missing or empty");
    end

    // Record type in the low nibble and test number above it
    test_id = 2;
    idx = 0;
    while (idx < rec_w * max_rec && stim_mem[idx][3:0] != 4'd0) begin
      if (stim_mem[idx][7:4] != test_id) begin
        drain_pipe();
        end_test(test_id);
        test_id = stim_mem[idx][7:4];
      end
      case (stim_mem[idx][3:0])
        4'd1: load_config(stim_mem[idx+1][15:0], stim_mem[idx+2][0], stim_mem[idx+3][3:0]);
        4'd2: drive_pixel(stim_mem[idx+1][3:0], stim_mem[idx+2][3*cw-1:0],
                          stim_mem[idx+3][2:0], stim_mem[idx+4][3*cw-1:0]);
        4'd3: begin
          repeat (stim_mem[idx+1]) begin
            r   = $random(seed);
            ctl = r[27:24];
            rgb = r[3*cw-1:0];
            e   = model_pixel(ctl, rgb);
            drive_pixel(ctl, rgb, e[3*cw+2:3*cw], e[3*cw-1:0]);
          end
        end
        default: begin
          errors++;
          $display("unknown stimulus record type at word %0d", idx);
        end
      endcase
      idx += rec_w;
    end
    drain_pipe();
    end_test(test_id);
    finish_run();
  end

endmodule
